//--- src/reg_cfg_pkg.sv
// Sizing constants for the integer register file subsystem.
// Imported by the interface package, the RTL blocks and the testbench.
package reg_cfg_pkg;

    localparam int XLEN       = 32;  // Register width
    localparam int TAG_W      = 3;   // Writeback tag width that wraps modulo 2**TAG_W
    localparam int REG_AW     = 5;   // Register index width
    localparam int REGS_TOTAL = 32;  // x0 included

    // ABI registers tapped for the branch predictor and border checker
    localparam int REG_RA = 1;
    localparam int REG_SP = 2;

    // Debug bus geometry
    localparam int AXIL_AW = 8;
    localparam int AXIL_DW = 32;

    // Debug address map with the index in bits 6..2 and bit 7 unmapped
    localparam int AXIL_IDX_LSB = 2;
    localparam int AXIL_ERR_BIT = 7;

endpackage

//--- src/reg_if_pkg.sv
// Packed payload types shared by the register file blocks.
// Covers the core writeback, the internal entry buses, the read answers
// and the AXI4-Lite channel payloads of the debug port.
package reg_if_pkg;

    import reg_cfg_pkg::*;

    // AXI response codes
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // 42-bit writeback from the core
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] addr;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   data;
        logic              inorder;  // Only write if the tag is next in sequence
    } wb_req_t;

    // 39-bit debug access from the AXI slave
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   wdata;
    } dbg_req_t;

    // Write command for a single entry
    typedef struct packed {
        logic             we;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  val;
        logic             keep_tag;  // Debug writes leave the tag alone
    } entry_wr_t;

    // Stored state of one entry
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  val;
    } entry_t;

    // Read port answer
    typedef struct packed {
        logic [XLEN-1:0]  val;
        logic [TAG_W-1:0] tag;
    } rd_rsp_t;

    typedef struct packed {
        logic [AXIL_AW-1:0] addr;
        logic [2:0]         prot;
    } axil_aw_t;

    typedef struct packed {
        logic [AXIL_DW-1:0]   data;
        logic [AXIL_DW/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [AXIL_DW-1:0] data;
        logic [1:0]         resp;
    } axil_r_t;

endpackage

//--- src/reg_entry.sv
// One integer register with its writeback tag.
// Flags whether the incoming writeback tag is the next one in sequence,
// and loads value and tag from the write controller's command.
`timescale 1ns/1ps

module reg_entry (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  reg_if_pkg::entry_wr_t         i_wr,
    input  logic [reg_cfg_pkg::TAG_W-1:0] i_tag,    // Tag of the current writeback
    output reg_if_pkg::entry_t            o_entry,
    output logic                          o_seq_ok
);

    import reg_cfg_pkg::*;

    logic [TAG_W-1:0] next_tag;

    assign next_tag = o_entry.tag + 1'b1;  // Wraps at TAG_W bits
    assign o_seq_ok = (i_tag == next_tag);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_entry <= '0;
        end else if (i_wr.we) begin
            o_entry.val <= i_wr.val;
            if (!i_wr.keep_tag) begin
                o_entry.tag <= i_wr.tag;
            end
        end
    end

endmodule

//--- src/reg_write_ctrl.sv
// Write arbiter of the register file.
// Decides whether the core writeback is taken, holds off debug writes
// while a writeback targets a real register, and decodes the winning
// write into one command per entry. x0 has no entry, so its writes vanish.
`timescale 1ns/1ps

module reg_write_ctrl (
    input  reg_if_pkg::wb_req_t                i_wb,
    input  reg_if_pkg::dbg_req_t               i_dbg,
    input  logic [reg_cfg_pkg::REGS_TOTAL-1:1] i_seq_ok,
    output reg_if_pkg::entry_wr_t              o_wr [reg_cfg_pkg::REGS_TOTAL-1:1],
    output logic                               o_dbg_grant,
    output logic                               o_ignored
);

    import reg_cfg_pkg::*;

    logic wb_hold;    // Writeback owns the write port this cycle
    logic wb_seq_ok;
    logic wb_take;
    logic dbg_wr_go;

    // Sequence flag of the addressed entry which is never set for x0
    always_comb begin
        wb_seq_ok = 1'b0;
        for (int i = 1; i < REGS_TOTAL; i++) begin
            if (i_wb.addr == REG_AW'(i)) begin
                wb_seq_ok = i_seq_ok[i];
            end
        end
    end

    assign wb_hold   = i_wb.valid && (i_wb.addr != '0);
    assign wb_take   = wb_hold && (!i_wb.inorder || wb_seq_ok);
    assign o_ignored = wb_hold && i_wb.inorder && !wb_seq_ok;  // For the tracer

    // Even a refused ordered write blocks the debugger
    assign o_dbg_grant = i_dbg.valid && (!i_dbg.write || !wb_hold);
    assign dbg_wr_go   = o_dbg_grant && i_dbg.write;

    always_comb begin
        for (int i = 1; i < REGS_TOTAL; i++) begin
            o_wr[i].we = (wb_take && (i_wb.addr == REG_AW'(i)))
                       || (dbg_wr_go && (i_dbg.addr == REG_AW'(i)));
            o_wr[i].tag      = i_wb.tag;
            o_wr[i].val      = wb_take ? i_wb.data : i_dbg.wdata;
            o_wr[i].keep_tag = !wb_take;  // Debug write keeps the stored tag
        end
    end

endmodule

//--- src/reg_read_mux.sv
// Read side of the register file.
// Serves both core read ports and the debug read from the entry array,
// returning zero with tag zero for x0. Also taps ra and sp for the
// branch predictor and the border checker.
`timescale 1ns/1ps

module reg_read_mux (
    input  reg_if_pkg::entry_t              i_regs [reg_cfg_pkg::REGS_TOTAL-1:1],
    input  logic [reg_cfg_pkg::REG_AW-1:0]  i_radr1,
    input  logic [reg_cfg_pkg::REG_AW-1:0]  i_radr2,
    input  logic [reg_cfg_pkg::REG_AW-1:0]  i_dbg_addr,
    output reg_if_pkg::rd_rsp_t             o_rd1,
    output reg_if_pkg::rd_rsp_t             o_rd2,
    output logic [reg_cfg_pkg::XLEN-1:0]    o_dbg_rdata,
    output logic [reg_cfg_pkg::XLEN-1:0]    o_ra,
    output logic [reg_cfg_pkg::XLEN-1:0]    o_sp
);

    import reg_cfg_pkg::*;
    import reg_if_pkg::*;

    entry_t sel1;
    entry_t sel2;
    entry_t sel_dbg;

    // Index 0 matches no entry and stays zero
    always_comb begin
        sel1    = '0;
        sel2    = '0;
        sel_dbg = '0;
        for (int i = 1; i < REGS_TOTAL; i++) begin
            if (i_radr1 == REG_AW'(i)) begin
                sel1 = i_regs[i];
            end
            if (i_radr2 == REG_AW'(i)) begin
                sel2 = i_regs[i];
            end
            if (i_dbg_addr == REG_AW'(i)) begin
                sel_dbg = i_regs[i];
            end
        end
    end

    assign o_rd1.val   = sel1.val;
    assign o_rd1.tag   = sel1.tag;
    assign o_rd2.val   = sel2.val;
    assign o_rd2.tag   = sel2.tag;
    assign o_dbg_rdata = sel_dbg.val;

    assign o_ra = i_regs[REG_RA].val;  // Return address
    assign o_sp = i_regs[REG_SP].val;  // Stack pointer

endmodule

//--- src/dbg_axil_port.sv
// AXI4-Lite slave for the debug module.
// Turns one bus transfer at a time into a debug register access, with
// writes ahead of reads. AW and W are taken together once the write
// controller grants the access; a write held by core writebacks waits.
// Addresses with bit 7 set touch nothing and answer SLVERR.
`timescale 1ns/1ps

module dbg_axil_port (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    // Write address and data
    input  logic                         i_awvalid,
    output logic                         o_awready,
    input  reg_if_pkg::axil_aw_t         i_aw,
    input  logic                         i_wvalid,
    output logic                         o_wready,
    input  reg_if_pkg::axil_w_t          i_w,
    // Write response
    output logic                         o_bvalid,
    input  logic                         i_bready,
    output logic [1:0]                   o_bresp,
    // Read address and data
    input  logic                         i_arvalid,
    output logic                         o_arready,
    input  logic [reg_cfg_pkg::AXIL_AW-1:0] i_araddr,
    output logic                         o_rvalid,
    input  logic                         i_rready,
    output reg_if_pkg::axil_r_t          o_r,
    // Register file side
    output reg_if_pkg::dbg_req_t         o_req,
    input  logic                         i_grant,
    input  logic [reg_cfg_pkg::XLEN-1:0] i_rdata
);

    import reg_cfg_pkg::*;
    import reg_if_pkg::*;

    logic aw_err;
    logic ar_err;
    logic wr_want;
    logic rd_want;
    logic wr_fire;
    logic rd_fire;

    assign aw_err = i_aw.addr[AXIL_ERR_BIT];
    assign ar_err = i_araddr[AXIL_ERR_BIT];

    // Both halves of the write present and no write response outstanding
    assign wr_want = i_awvalid && i_wvalid && !o_bvalid;
    // A read waits behind any write on the bus
    assign rd_want = i_arvalid && !o_rvalid && !wr_want;

    always_comb begin
        o_req.valid = (wr_want && !aw_err) || (rd_want && !ar_err);
        o_req.write = wr_want;
        o_req.addr  = wr_want ? i_aw.addr[AXIL_IDX_LSB +: REG_AW]
                              : i_araddr[AXIL_IDX_LSB +: REG_AW];
        o_req.wdata = i_w.data;  // Strobes ignored as the whole register is written
    end

    // Unmapped accesses complete without a grant
    assign wr_fire = wr_want && (aw_err || i_grant);
    assign rd_fire = rd_want && (ar_err || i_grant);

    assign o_awready = wr_fire;
    assign o_wready  = wr_fire;
    assign o_arready = rd_fire;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end

            if (rd_fire) begin
                o_rvalid <= 1'b1;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    // Response payloads held until the master takes them
    always_ff @(posedge i_clk) begin
        if (wr_fire) begin
            o_bresp <= aw_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
        if (rd_fire) begin
            o_r.data <= ar_err ? '0 : i_rdata;
            o_r.resp <= ar_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
    end

endmodule

//--- src/int_reg_bank.sv
// Integer register file of the core.
// Two combinational read ports with tags, one tagged writeback port with
// optional in-order check, an AXI4-Lite debug port and live ra/sp taps.
// Core writebacks win over debug writes, which wait on bus back-pressure.
`timescale 1ns/1ps

module int_reg_bank (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    // Core side
    input  reg_if_pkg::wb_req_t            i_wb,
    input  logic [reg_cfg_pkg::REG_AW-1:0] i_radr1,
    input  logic [reg_cfg_pkg::REG_AW-1:0] i_radr2,
    output reg_if_pkg::rd_rsp_t            o_rd1,
    output reg_if_pkg::rd_rsp_t            o_rd2,
    output logic                           o_ignored,
    output logic [reg_cfg_pkg::XLEN-1:0]   o_ra,
    output logic [reg_cfg_pkg::XLEN-1:0]   o_sp,
    // Debug AXI4-Lite
    input  logic                           i_awvalid,
    output logic                           o_awready,
    input  reg_if_pkg::axil_aw_t           i_aw,
    input  logic                           i_wvalid,
    output logic                           o_wready,
    input  reg_if_pkg::axil_w_t            i_w,
    output logic                           o_bvalid,
    input  logic                           i_bready,
    output logic [1:0]                     o_bresp,
    input  logic                           i_arvalid,
    output logic                           o_arready,
    input  logic [reg_cfg_pkg::AXIL_AW-1:0] i_araddr,
    output logic                           o_rvalid,
    input  logic                           i_rready,
    output reg_if_pkg::axil_r_t            o_r
);

    import reg_cfg_pkg::*;
    import reg_if_pkg::*;

    dbg_req_t              dbg_req;
    logic                  dbg_grant;
    logic [XLEN-1:0]       dbg_rdata;
    entry_wr_t             wr [REGS_TOTAL-1:1];
    entry_t                regs [REGS_TOTAL-1:1];
    logic [REGS_TOTAL-1:1] seq_ok;

    dbg_axil_port u_dbg (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_aw      (i_aw),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_w       (i_w),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_r       (o_r),
        .o_req     (dbg_req),
        .i_grant   (dbg_grant),
        .i_rdata   (dbg_rdata)
    );

    reg_write_ctrl u_wctrl (
        .i_wb        (i_wb),
        .i_dbg       (dbg_req),
        .i_seq_ok    (seq_ok),
        .o_wr        (wr),
        .o_dbg_grant (dbg_grant),
        .o_ignored   (o_ignored)
    );

    // Storage for x1..x31 only as x0 reads zero
    for (genvar i = 1; i < REGS_TOTAL; i++) begin : g_entry
        reg_entry u_entry (
            .i_clk    (i_clk),
            .i_nrst   (i_nrst),
            .i_wr     (wr[i]),
            .i_tag    (i_wb.tag),
            .o_entry  (regs[i]),
            .o_seq_ok (seq_ok[i])
        );
    end

    reg_read_mux u_rmux (
        .i_regs      (regs),
        .i_radr1     (i_radr1),
        .i_radr2     (i_radr2),
        .i_dbg_addr  (dbg_req.addr),
        .o_rd1       (o_rd1),
        .o_rd2       (o_rd2),
        .o_dbg_rdata (dbg_rdata),
        .o_ra        (o_ra),
        .o_sp        (o_sp)
    );

endmodule

//--- test/tb_int_reg_bank.sv
// Directed testbench for the integer register file.
// Keeps a model of every value and tag, drives core writebacks and AXI4-Lite
// debug transfers, and checks read ports, the ignored flag and the ra/sp taps.
`timescale 1ns/1ps

module tb_int_reg_bank;

    import reg_cfg_pkg::*;
    import reg_if_pkg::*;

    localparam int TEST_CYCLES    = 10 + 35 + 80 + 22 + 16 + 9 + 7;  // Reset plus each test
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic               i_clk;
    logic               i_nrst;
    wb_req_t            i_wb;
    logic [REG_AW-1:0]  i_radr1;
    logic [REG_AW-1:0]  i_radr2;
    rd_rsp_t            o_rd1;
    rd_rsp_t            o_rd2;
    logic               o_ignored;
    logic [XLEN-1:0]    o_ra;
    logic [XLEN-1:0]    o_sp;
    logic               i_awvalid;
    logic               o_awready;
    axil_aw_t           i_aw;
    logic               i_wvalid;
    logic               o_wready;
    axil_w_t            i_w;
    logic               o_bvalid;
    logic               i_bready;
    logic [1:0]         o_bresp;
    logic               i_arvalid;
    logic               o_arready;
    logic [AXIL_AW-1:0] i_araddr;
    logic               o_rvalid;
    logic               i_rready;
    axil_r_t            o_r;

    logic [XLEN-1:0]  m_val [REGS_TOTAL];  // Reference model where x0 stays zero
    logic [TAG_W-1:0] m_tag [REGS_TOTAL];
    logic [31:0]      lfsr   = 32'hbc5d;
    int               errors = 0;
    int               checks = 0;
    int               cycles = 0;

    int_reg_bank dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'hb4bcd35c;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [AXIL_AW-1:0] reg_addr(input logic [REG_AW-1:0] idx);
        return {1'b0, idx, 2'b00};  // Byte address of a register
    endfunction

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Both read ports plus the ra/sp taps against the model
    task automatic check_read(input logic [REG_AW-1:0] a1, input logic [REG_AW-1:0] a2);
        i_radr1 = a1;
        i_radr2 = a2;
        @(negedge i_clk);
        expect_eq(o_rd1.val, m_val[a1], "read port 1 value");
        expect_eq(o_rd1.tag, m_tag[a1], "read port 1 tag");
        expect_eq(o_rd2.val, m_val[a2], "read port 2 value");
        expect_eq(o_rd2.tag, m_tag[a2], "read port 2 tag");
        expect_eq(o_ra, m_val[REG_RA], "return address tap");
        expect_eq(o_sp, m_val[REG_SP], "stack pointer tap");
        next_cycle();
    endtask

    task automatic wb_write(input logic [REG_AW-1:0] addr, input logic [TAG_W-1:0] tag,
                            input logic [XLEN-1:0] data, input logic inorder);
        logic [TAG_W-1:0] want_tag;
        logic             refused;
        want_tag = m_tag[addr] + 1'b1;
        refused  = (addr != 0) && inorder && (tag != want_tag);
        i_wb.valid   = 1'b1;
        i_wb.addr    = addr;
        i_wb.tag     = tag;
        i_wb.data    = data;
        i_wb.inorder = inorder;
        @(negedge i_clk);
        expect_eq(o_ignored, refused, "ignored flag");
        next_cycle();
        i_wb = '0;
        if (addr != 0 && !refused) begin
            m_val[addr] = data;
            m_tag[addr] = tag;
        end
    endtask

    // Debug write that keeps the stored tag
    task automatic axil_write(input logic [AXIL_AW-1:0] addr, input logic [XLEN-1:0] data);
        i_awvalid  = 1'b1;
        i_aw.addr  = addr;
        i_aw.prot  = '0;
        i_wvalid   = 1'b1;
        i_w.data   = data;
        i_w.strb   = 4'hf;
        @(negedge i_clk);
        while (!(o_awready && o_wready)) begin
            @(negedge i_clk);
        end
        next_cycle();
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        i_bready  = 1'b1;
        @(negedge i_clk);
        expect_eq(o_bvalid, 1'b1, "bvalid one cycle after AW/W");
        expect_eq(o_bresp, addr[7] ? AXI_RESP_SLVERR : AXI_RESP_OKAY, "write response");
        next_cycle();
        i_bready = 1'b0;
        if (!addr[7] && addr[6:2] != 0) begin
            m_val[addr[6:2]] = data;
        end
    endtask

    task automatic axil_read(input logic [AXIL_AW-1:0] addr);
        i_arvalid = 1'b1;
        i_araddr  = addr;
        @(negedge i_clk);
        while (!o_arready) begin
            @(negedge i_clk);
        end
        next_cycle();
        i_arvalid = 1'b0;
        i_rready  = 1'b1;
        @(negedge i_clk);
        expect_eq(o_rvalid, 1'b1, "rvalid one cycle after AR");
        expect_eq(o_r.resp, addr[7] ? AXI_RESP_SLVERR : AXI_RESP_OKAY, "read response");
        if (!addr[7]) begin
            expect_eq(o_r.data, m_val[addr[6:2]], "debug read data");
        end
        next_cycle();
        i_rready = 1'b0;
    endtask

    task automatic reset_reads_zero();
        for (int i = 0; i < REGS_TOTAL; i++) begin
            check_read(REG_AW'(i), REG_AW'(REGS_TOTAL - 1 - i));
        end
        wb_write(5'd0, 3'd5, lfsr_bits(32), 1'b0);
        wb_write(5'd0, 3'd1, lfsr_bits(32), 1'b1);  // x0 never flags ignored
        check_read(5'd0, 5'd0);
    endtask

    task automatic unordered_writeback();
        logic [REG_AW-1:0] addr;
        logic [REG_AW-1:0] prev;
        prev = 5'd0;
        repeat (40) begin
            addr = lfsr_bits(REG_AW);
            if (addr == 0) begin
                addr = 5'd31;
            end
            wb_write(addr, lfsr_bits(TAG_W), lfsr_bits(XLEN), 1'b0);
            check_read(addr, prev);
            prev = addr;
        end
    endtask

    // Nine steps in a row cross the 7 to 0 wrap from any start tag
    task automatic ordered_tag_check();
        logic [TAG_W-1:0] t;
        repeat (9) begin
            t = m_tag[5] + 1'b1;
            wb_write(5'd5, t, lfsr_bits(XLEN), 1'b1);
            check_read(5'd5, 5'd0);
        end
        wb_write(5'd5, m_tag[5] + 3'd3, lfsr_bits(XLEN), 1'b1);
        check_read(5'd5, 5'd5);
        wb_write(5'd5, m_tag[5], lfsr_bits(XLEN), 1'b1);
        check_read(5'd5, 5'd0);
    endtask

    task automatic debug_bus_access();
        wb_write(5'd7, 3'd6, lfsr_bits(XLEN), 1'b0);  // Nonzero tag for the debug write to keep
        axil_write(reg_addr(5'd7), lfsr_bits(XLEN));
        check_read(5'd7, 5'd0);
        axil_read(reg_addr(5'd7));
        axil_read(reg_addr(5'd3));
        axil_write(8'h80 | reg_addr(5'd4), lfsr_bits(XLEN));  // Unmapped address answers SLVERR
        check_read(5'd4, 5'd7);
        axil_read(8'h80 | reg_addr(5'd4));
        axil_write(reg_addr(5'd0), lfsr_bits(XLEN));
        check_read(5'd0, 5'd7);
    endtask

    // Debug write against six back-to-back writebacks
    task automatic contested_debug_write();
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   dbg_data;
        dbg_data = lfsr_bits(XLEN);
        fork
            axil_write(reg_addr(5'd9), dbg_data);
            for (int k = 0; k < 6; k++) begin
                addr = REG_AW'(10 + k);
                wb_write(addr, lfsr_bits(TAG_W), lfsr_bits(XLEN), 1'b0);
            end
            begin
                repeat (6) begin
                    @(negedge i_clk);
                    expect_eq(o_awready, 1'b0, "awready while core writes");
                    expect_eq(o_bvalid, 1'b0, "bvalid while core writes");
                end
                @(negedge i_clk);
                expect_eq(o_awready, 1'b1, "held write accepted after writebacks");
            end
        join
        check_read(5'd9, 5'd10);
    endtask

    task automatic abi_tap_tracking();
        wb_write(REG_AW'(REG_RA), lfsr_bits(TAG_W), lfsr_bits(XLEN), 1'b0);
        check_read(REG_AW'(REG_RA), REG_AW'(REG_SP));
        wb_write(REG_AW'(REG_SP), lfsr_bits(TAG_W), lfsr_bits(XLEN), 1'b0);
        check_read(REG_AW'(REG_SP), REG_AW'(REG_RA));
        axil_write(reg_addr(REG_AW'(REG_SP)), lfsr_bits(XLEN));
        check_read(REG_AW'(REG_SP), REG_AW'(REG_SP));
    endtask

    initial begin
        i_nrst    = 1'b0;
        i_wb      = '0;
        i_radr1   = '0;
        i_radr2   = '0;
        i_awvalid = 1'b0;
        i_aw      = '0;
        i_wvalid  = 1'b0;
        i_w       = '0;
        i_bready  = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_rready  = 1'b0;
        for (int i = 0; i < REGS_TOTAL; i++) begin
            m_val[i] = '0;
            m_tag[i] = '0;
        end
        repeat (10) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;
        reset_reads_zero();
        unordered_writeback();
        ordered_tag_check();
        debug_bus_access();
        contested_debug_write();
        abi_tap_tracking();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- compile.f
src/reg_cfg_pkg.sv
src/reg_if_pkg.sv
src/reg_entry.sv
src/reg_write_ctrl.sv
src/reg_read_mux.sv
src/dbg_axil_port.sv
src/int_reg_bank.sv
test/tb_int_reg_bank.sv

//--- Bender.yml
package:
  name: int_reg_bank

sources:
  - src/reg_cfg_pkg.sv
  - src/reg_if_pkg.sv
  - src/reg_entry.sv
  - src/reg_write_ctrl.sv
  - src/reg_read_mux.sv
  - src/dbg_axil_port.sv
  - src/int_reg_bank.sv
  - target: test
    files:
      - test/tb_int_reg_bank.sv
